// File: Bender.yml
package:
  name: xaui_pipe

sources:
  - xaui_pkg.sv
  - xaui_sync_fifo.sv
  - xaui_apb_regs.sv
  - xaui_transfer_engine.sv
  - xaui_link_monitor.sv
  - xaui_pipe.sv
  - target: test
    files:
      - xaui_pipe_tb.sv

// File: verilog.f
xaui_pkg.sv
xaui_sync_fifo.sv
xaui_apb_regs.sv
xaui_transfer_engine.sv
xaui_link_monitor.sv
xaui_pipe.sv
xaui_pipe_tb.sv

// File: xaui_apb_regs.sv
`default_nettype none

module xaui_apb_regs (
  input  wire                           mgt_clk,
  input  wire                           reset,
  input  wire                           psel_i,
  input  wire                           penable_i,
  input  wire                           pwrite_i,
  input  wire  [7:0]                    paddr_i,
  input  wire  [31:0]                   pwdata_i,
  output logic [31:0]                   prdata_o,
  output logic                          pready_o,
  output logic                          pslverr_o,
  output logic                          tx_push_o,
  output xaui_pkg::xgmii_word_t         tx_data_o,
  input  wire                           tx_empty_i,
  input  wire                           tx_full_i,
  output logic                          rx_pop_o,
  input  wire  xaui_pkg::rx_entry_t     rx_head_i,
  input  wire                           rx_empty_i,
  input  wire                           rx_full_i,
  output logic                          tx_en_o,
  output logic                          loopback_o,
  output logic                          flush_o,
  input  wire                           link_up_i,
  input  wire  [xaui_pkg::CNT_W-1:0]    tx_count_i,
  input  wire  [xaui_pkg::CNT_W-1:0]    rx_count_i,
  input  wire  [xaui_pkg::CNT_W-1:0]    ovf_count_i
);
  import xaui_pkg::*;

  logic        wr_acc;
  logic        rd_acc;
  logic        addr_hit;
  logic [31:0] tx_lo_q;

  // access phase of a transfer, never stretched
  assign wr_acc   = psel_i && penable_i && pwrite_i;
  assign rd_acc   = psel_i && penable_i && !pwrite_i;
  assign pready_o = 1'b1;

  // ========================================
  // fifo side effects
  // ========================================

  assign tx_push_o = wr_acc && (paddr_i == REG_TX_HI) && !tx_full_i;
  assign tx_data_o = {pwdata_i, tx_lo_q};
  assign rx_pop_o  = rd_acc && (paddr_i == REG_RX_HI) && !rx_empty_i;

  // soft reset strobe, lives only for the access cycle
  assign flush_o = wr_acc && (paddr_i == REG_CTRL) && pwdata_i[2];

  always_ff @(posedge mgt_clk) begin
    if (reset) begin
      tx_en_o    <= 1'b0;
      loopback_o <= 1'b0;
    end else if (wr_acc && (paddr_i == REG_CTRL)) begin
      tx_en_o    <= pwdata_i[0];
      loopback_o <= pwdata_i[1];
    end
  end

  // low half waits here for the high half write
  always_ff @(posedge mgt_clk) begin
    if (wr_acc && (paddr_i == REG_TX_LO)) begin
      tx_lo_q <= pwdata_i;
    end
  end

  // ========================================
  // read mux and error response
  // ========================================

  always_comb begin
    prdata_o = '0;
    addr_hit = 1'b1;
    case (paddr_i)
      REG_CTRL:      prdata_o = {30'd0, loopback_o, tx_en_o};
      REG_STATUS:    prdata_o = {27'd0, link_up_i, rx_full_i, rx_empty_i, tx_full_i, tx_empty_i};
      REG_TX_LO:     prdata_o = tx_lo_q;
      REG_TX_HI:     prdata_o = '0;
      REG_RX_LO:     prdata_o = rx_head_i.data[31:0];
      REG_RX_HI:     prdata_o = rx_head_i.data[63:32];
      REG_RX_CTRL:   prdata_o = {24'd0, rx_head_i.ctrl};
      REG_TX_COUNT:  prdata_o = {{(32 - CNT_W){1'b0}}, tx_count_i};
      REG_RX_COUNT:  prdata_o = {{(32 - CNT_W){1'b0}}, rx_count_i};
      REG_OVF_COUNT: prdata_o = {{(32 - CNT_W){1'b0}}, ovf_count_i};
      default:       addr_hit = 1'b0;
    endcase
  end

  // dropped push, pop on empty, or no register there
  assign pslverr_o = (psel_i && penable_i && !addr_hit) ||
                     (wr_acc && (paddr_i == REG_TX_HI) && tx_full_i) ||
                     (rd_acc && (paddr_i == REG_RX_HI) && rx_empty_i);

endmodule

`default_nettype wire

// File: xaui_link_monitor.sv
`default_nettype none

module xaui_link_monitor (
  input  wire                        mgt_clk,
  input  wire                        reset,
  input  wire                        tx_strb_i,
  input  wire                        rx_strb_i,
  input  wire                        ovf_strb_i,
  input  wire                        idle_seen_i,
  input  wire                        fault_seen_i,
  output logic                       link_up_o,
  output logic [xaui_pkg::CNT_W-1:0] tx_count_o,
  output logic [xaui_pkg::CNT_W-1:0] rx_count_o,
  output logic [xaui_pkg::CNT_W-1:0] ovf_count_o,
  output logic [2:0]                 leds_o
);
  import xaui_pkg::*;

  typedef logic [$clog2(LED_STRETCH + 1)-1:0] led_cnt_t;

  logic [2:0]       cnt_strb;
  logic [CNT_W-1:0] cnt_q [3];
  logic [2:0]       led_trig;
  led_cnt_t         led_cnt_q [3];

  // ========================================
  // saturating event counters
  // ========================================

  assign cnt_strb = {ovf_strb_i, rx_strb_i, tx_strb_i};

  for (genvar i = 0; i < 3; i++) begin : g_cnt
    always_ff @(posedge mgt_clk) begin
      if (reset) begin
        cnt_q[i] <= '0;
      end else if (cnt_strb[i] && (cnt_q[i] != '1)) begin
        cnt_q[i] <= cnt_q[i] + 1'b1;
      end
    end
  end

  assign tx_count_o  = cnt_q[0];
  assign rx_count_o  = cnt_q[1];
  assign ovf_count_o = cnt_q[2];

  // last idle or fault decides
  always_ff @(posedge mgt_clk) begin
    if (reset) begin
      link_up_o <= 1'b0;
    end else if (fault_seen_i) begin
      link_up_o <= 1'b0;
    end else if (idle_seen_i) begin
      link_up_o <= 1'b1;
    end
  end

  // ========================================
  // led stretch
  // ========================================

  // bit 2 rx, bit 1 tx, bit 0 link down
  assign led_trig = {rx_strb_i, tx_strb_i, fault_seen_i};

  for (genvar i = 0; i < 3; i++) begin : g_led
    // a strobe during the on-time is absorbed
    always_ff @(posedge mgt_clk) begin
      if (reset) begin
        led_cnt_q[i] <= '0;
      end else if (led_cnt_q[i] != '0) begin
        led_cnt_q[i] <= led_cnt_q[i] - 1'b1;
      end else if (led_trig[i]) begin
        led_cnt_q[i] <= led_cnt_t'(LED_STRETCH);
      end
    end
    assign leds_o[i] = (led_cnt_q[i] != '0);
  end

endmodule

`default_nettype wire

// File: xaui_pipe.sv
`default_nettype none

module xaui_pipe (
  input  wire                         mgt_clk,
  input  wire                         reset,
  input  wire                         psel_i,
  input  wire                         penable_i,
  input  wire                         pwrite_i,
  input  wire  [7:0]                  paddr_i,
  input  wire  [31:0]                 pwdata_i,
  output logic [31:0]                 prdata_o,
  output logic                        pready_o,
  output logic                        pslverr_o,
  input  wire  xaui_pkg::xgmii_word_t xgmii_rxd_i,
  input  wire  xaui_pkg::xgmii_ctrl_t xgmii_rxc_i,
  output xaui_pkg::xgmii_word_t       xgmii_txd_o,
  output xaui_pkg::xgmii_ctrl_t       xgmii_txc_o,
  output logic [2:0]                  leds_o
);
  import xaui_pkg::*;

  logic             tx_push;
  logic             tx_pop;
  xgmii_word_t      tx_wdata;
  xgmii_word_t      tx_head;
  logic             tx_empty;
  logic             tx_full;
  logic             rx_push;
  logic             rx_pop;
  rx_entry_t        rx_wentry;
  rx_entry_t        rx_head;
  logic             rx_empty;
  logic             rx_full;
  logic             tx_en;
  logic             loopback;
  logic             flush;
  logic             link_up;
  logic [CNT_W-1:0] tx_count;
  logic [CNT_W-1:0] rx_count;
  logic [CNT_W-1:0] ovf_count;
  logic             tx_strb;
  logic             rx_strb;
  logic             ovf_strb;
  logic             idle_seen;
  logic             fault_seen;

  // ========================================
  // host side
  // ========================================

  xaui_apb_regs regs_i (
    .mgt_clk, .reset,
    .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .tx_push_o(tx_push), .tx_data_o(tx_wdata),
    .tx_empty_i(tx_empty), .tx_full_i(tx_full),
    .rx_pop_o(rx_pop), .rx_head_i(rx_head),
    .rx_empty_i(rx_empty), .rx_full_i(rx_full),
    .tx_en_o(tx_en), .loopback_o(loopback), .flush_o(flush),
    .link_up_i(link_up), .tx_count_i(tx_count),
    .rx_count_i(rx_count), .ovf_count_i(ovf_count)
  );

  xaui_sync_fifo #(.payload_t(xgmii_word_t)) tx_fifo (
    .mgt_clk, .reset, .flush_i(flush),
    .push_i(tx_push), .pop_i(tx_pop), .data_i(tx_wdata),
    .data_o(tx_head), .empty_o(tx_empty), .full_o(tx_full)
  );

  xaui_sync_fifo #(.payload_t(rx_entry_t)) rx_fifo (
    .mgt_clk, .reset, .flush_i(flush),
    .push_i(rx_push), .pop_i(rx_pop), .data_i(rx_wentry),
    .data_o(rx_head), .empty_o(rx_empty), .full_o(rx_full)
  );

  // ========================================
  // line side
  // ========================================

  xaui_transfer_engine engine_i (
    .mgt_clk, .reset, .flush_i(flush),
    .tx_en_i(tx_en), .loopback_i(loopback),
    .tx_head_i(tx_head), .tx_empty_i(tx_empty), .tx_pop_o(tx_pop),
    .rx_push_o(rx_push), .rx_entry_o(rx_wentry), .rx_full_i(rx_full),
    .xgmii_rxd_i, .xgmii_rxc_i, .xgmii_txd_o, .xgmii_txc_o,
    .tx_strb_o(tx_strb), .rx_strb_o(rx_strb), .ovf_strb_o(ovf_strb),
    .idle_seen_o(idle_seen), .fault_seen_o(fault_seen)
  );

  xaui_link_monitor monitor_i (
    .mgt_clk, .reset,
    .tx_strb_i(tx_strb), .rx_strb_i(rx_strb), .ovf_strb_i(ovf_strb),
    .idle_seen_i(idle_seen), .fault_seen_i(fault_seen),
    .link_up_o(link_up), .tx_count_o(tx_count),
    .rx_count_o(rx_count), .ovf_count_o(ovf_count), .leds_o
  );

endmodule

`default_nettype wire

// File: xaui_pipe_tb.sv
`default_nettype none

module xaui_pipe_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import xaui_pkg::*;

  logic        mgt_clk;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  xgmii_word_t rxd;
  xgmii_ctrl_t rxc;
  xgmii_word_t txd;
  xgmii_ctrl_t txc;
  logic [2:0]  leds;

  // reference model state
  logic [63:0] tx_q [$];
  logic [71:0] rx_q [$];
  int          mdl_tx;
  int          mdl_rx;
  int          mdl_ovf;
  logic        mdl_link;

  int          errors;
  int          tests;
  int          failed;
  int          start;
  int          n;
  logic [31:0] rd;
  logic        err;
  logic        exp_err;
  logic [63:0] w;
  logic [71:0] ent;
  logic        rose;
  logic        fell;

  xaui_pipe dut_i (
    .mgt_clk, .reset,
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .paddr_i(paddr), .pwdata_i(pwdata),
    .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
    .xgmii_rxd_i(rxd), .xgmii_rxc_i(rxc),
    .xgmii_txd_o(txd), .xgmii_txc_o(txc), .leds_o(leds)
  );

  initial begin
    mgt_clk = 1'b0;
    forever #10 mgt_clk = ~mgt_clk;
  end

  // ========================================
  // helpers
  // ========================================

  task automatic check(input string name, input logic [71:0] exp, input logic [71:0] act);
    if (exp !== act) begin
      $display("Fail %s: expected %0h, actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed", name);
      failed++;
    end
  endtask

  // setup cycle, then access cycle until pready
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic slverr);
    int waited;
    waited = 0;
    @(posedge mgt_clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge mgt_clk);
    penable <= 1'b1;
    @(negedge mgt_clk);
    while (!pready && waited < 16) begin
      @(negedge mgt_clk);
      waited++;
    end
    if (!pready) begin
      $display("timeout: no pready for address %0h", addr);
      errors++;
    end
    rdata  = prdata;
    slverr = pslverr;
    @(posedge mgt_clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic slverr);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused, slverr);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic slverr);
    apb_access(1'b0, addr, 32'd0, data, slverr);
  endtask

  // head entry as {ctrl, data}, the high half read pops it
  task automatic read_entry(output logic [71:0] entry, output logic slverr);
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] ctl;
    apb_read(REG_RX_LO, lo, slverr);
    apb_read(REG_RX_CTRL, ctl, slverr);
    apb_read(REG_RX_HI, hi, slverr);
    entry = {ctl[7:0], hi, lo};
  endtask

  task automatic wait_status(input int idx, input logic val, input string what);
    logic [31:0] st;
    logic        e;
    int          polls;
    polls = 0;
    apb_read(REG_STATUS, st, e);
    while (st[idx] !== val && polls < 50) begin
      apb_read(REG_STATUS, st, e);
      polls++;
    end
    if (st[idx] !== val) begin
      $display("timeout waiting for %s", what);
      errors++;
    end
  endtask

  // receive rules: idle sets link, fault clears it, the rest is stored or overflows
  function automatic void model_rx(input xgmii_word_t d, input xgmii_ctrl_t c);
    if (d == IDLE_WORD && c == IDLE_CTRL) begin
      mdl_link = 1'b1;
    end else if (d == FAULT_WORD && c == FAULT_CTRL) begin
      mdl_link = 1'b0;
    end else if (rx_q.size() < FIFO_DEPTH) begin
      rx_q.push_back({c, d});
      mdl_rx++;
    end else begin
      mdl_ovf++;
    end
  endfunction

  // word stays on the lanes until the next call
  task automatic drive_word(input xgmii_word_t d, input xgmii_ctrl_t c);
    @(posedge mgt_clk);
    rxd <= d;
    rxc <= c;
    model_rx(d, c);
  endtask

  task automatic check_counters(input string name);
    logic [31:0] v;
    logic        e;
    apb_read(REG_TX_COUNT, v, e);
    check({name, " tx count"}, mdl_tx, v);
    apb_read(REG_RX_COUNT, v, e);
    check({name, " rx count"}, mdl_rx, v);
    apb_read(REG_OVF_COUNT, v, e);
    check({name, " ovf count"}, mdl_ovf, v);
  endtask

  task automatic wait_led_low(input int idx);
    int cnt;
    cnt = 0;
    @(negedge mgt_clk);
    while (leds[idx] && cnt < LED_STRETCH + 4) begin
      @(negedge mgt_clk);
      cnt++;
    end
    if (leds[idx]) begin
      $display("timeout: led %0d stayed lit", idx);
      errors++;
    end
  endtask

  task automatic led_pulse(input int idx, output logic on, output logic off);
    int cnt;
    on  = 1'b0;
    off = 1'b0;
    cnt = 0;
    while (!off && cnt < LED_STRETCH + 4) begin
      @(negedge mgt_clk);
      if (leds[idx]) begin
        on = 1'b1;
      end else if (on) begin
        off = 1'b1;
      end
      cnt++;
    end
  endtask

  // ========================================
  // tests
  // ========================================

  initial begin
    void'($urandom(75972));
    errors   = 0;
    tests    = 0;
    failed   = 0;
    mdl_tx   = 0;
    mdl_rx   = 0;
    mdl_ovf  = 0;
    mdl_link = 1'b0;
    reset    = 1'b1;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    // fault on the line keeps the link down out of reset
    rxd      = FAULT_WORD;
    rxc      = FAULT_CTRL;
    repeat (16) @(posedge mgt_clk);
    reset <= 1'b0;

    // reset values and control readback
    start = errors;
    apb_read(REG_STATUS, rd, err);
    check("status after reset", 5'b00101, rd[4:0]);
    apb_write(REG_CTRL, 32'h3, err);
    apb_read(REG_CTRL, rd, err);
    check("ctrl readback", 32'h3, rd);
    apb_write(REG_CTRL, 32'h6, err);
    apb_read(REG_CTRL, rd, err);
    check("ctrl soft reset bit", 32'h2, rd);
    apb_write(REG_CTRL, 32'h0, err);
    end_test("reset_and_regs", start);

    // words loop back in order with control 0
    start = errors;
    drive_word(IDLE_WORD, IDLE_CTRL);
    n = 4 + ($urandom % 5);
    for (int i = 0; i < n; i++) begin
      w = {$urandom, $urandom};
      tx_q.push_back(w);
      apb_write(REG_TX_LO, w[31:0], err);
      apb_write(REG_TX_HI, w[63:32], err);
      check("tx push err", 1'b0, err);
    end
    apb_read(REG_STATUS, rd, err);
    check("tx full", (n == FIFO_DEPTH), rd[1]);
    check("tx empty", 1'b0, rd[0]);
    apb_write(REG_CTRL, 32'h3, err);
    // tx led follows the burst
    led_pulse(1, rose, fell);
    check("tx led lit", 1'b1, rose);
    check("tx led off", 1'b1, fell);
    while (tx_q.size() > 0) begin
      wait_status(2, 1'b0, "loopback entry");
      read_entry(ent, err);
      check("loopback word", {8'h00, tx_q.pop_front()}, ent);
    end
    mdl_tx += n;
    mdl_rx += n;
    apb_read(REG_STATUS, rd, err);
    check("rx empty after loopback", 1'b1, rd[2]);
    check_counters("loopback");
    apb_write(REG_CTRL, 32'h0, err);
    end_test("loopback", start);

    // random mix on the external lanes, nothing read until the end
    start = errors;
    for (int i = 0; i < 20; i++) begin
      case ($urandom % 4)
        0: drive_word(IDLE_WORD, IDLE_CTRL);
        1: drive_word(FAULT_WORD, FAULT_CTRL);
        default: drive_word({$urandom, $urandom}, 8'($urandom));
      endcase
    end
    if ($urandom % 2) begin
      drive_word(IDLE_WORD, IDLE_CTRL);
    end else begin
      drive_word(FAULT_WORD, FAULT_CTRL);
    end
    while (rx_q.size() > 0) begin
      wait_status(2, 1'b0, "received entry");
      read_entry(ent, err);
      check("rx entry", rx_q.pop_front(), ent);
    end
    apb_read(REG_STATUS, rd, err);
    check("rx drained", 1'b1, rd[2]);
    check("link up", mdl_link, rd[4]);
    check_counters("filter");
    drive_word(IDLE_WORD, IDLE_CTRL);
    end_test("rx_filter", start);

    // error responses
    start = errors;
    apb_read(REG_RX_HI, rd, err);
    check("rx hi on empty err", 1'b1, err);
    for (int i = 0; i <= FIFO_DEPTH; i++) begin
      w = {$urandom, $urandom};
      exp_err = (tx_q.size() >= FIFO_DEPTH);
      if (!exp_err) begin
        tx_q.push_back(w);
      end
      apb_write(REG_TX_LO, w[31:0], err);
      apb_write(REG_TX_HI, w[63:32], err);
      check("tx push err", exp_err, err);
    end
    apb_read(REG_STATUS, rd, err);
    check("tx still full", 2'b10, rd[1:0]);
    apb_read(8'h40, rd, err);
    check("unmapped read err", 1'b1, err);
    apb_write(8'h28, 32'h1, err);
    check("unmapped write err", 1'b1, err);
    end_test("errors", start);

    // activity leds
    start = errors;
    wait_led_low(2);
    drive_word({$urandom, $urandom}, 8'h00);
    drive_word(IDLE_WORD, IDLE_CTRL);
    led_pulse(2, rose, fell);
    check("rx led lit", 1'b1, rose);
    check("rx led off", 1'b1, fell);
    wait_led_low(0);
    drive_word(FAULT_WORD, FAULT_CTRL);
    drive_word(IDLE_WORD, IDLE_CTRL);
    led_pulse(0, rose, fell);
    check("link led lit", 1'b1, rose);
    check("link led off", 1'b1, fell);
    end_test("leds", start);

    // soft reset with both FIFOs full
    start = errors;
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      drive_word({$urandom, $urandom}, 8'h00);
    end
    drive_word(IDLE_WORD, IDLE_CTRL);
    wait_status(3, 1'b1, "rx full");
    apb_read(REG_STATUS, rd, err);
    check("full before flush", 4'b1010, rd[3:0]);
    check_counters("before flush");
    // transmit enabled together with the flush
    apb_write(REG_CTRL, 32'h5, err);
    tx_q.delete();
    rx_q.delete();
    apb_read(REG_STATUS, rd, err);
    check("status after flush", {mdl_link, 4'b0101}, rd[4:0]);
    @(negedge mgt_clk);
    check("xgmii idle after flush", {IDLE_CTRL, IDLE_WORD}, {txc, txd});
    check_counters("after flush");
    end_test("soft_reset", start);

    $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: xaui_pkg.sv
`default_nettype none

package xaui_pkg;

  // ========================================
  // xgmii lane types
  // ========================================

  // eight 8-bit lanes, lane 0 in bits 7:0
  typedef logic [63:0] xgmii_word_t;
  // one control flag per lane
  typedef logic [7:0]  xgmii_ctrl_t;

  // received word as kept in the rx FIFO
  typedef struct packed {
    xgmii_ctrl_t ctrl;
    xgmii_word_t data;
  } rx_entry_t;

  // ========================================
  // sizes
  // ========================================

  localparam int FIFO_DEPTH  = 8;
  localparam int FIFO_PTR_W  = $clog2(FIFO_DEPTH);
  localparam int LED_STRETCH = 64;
  localparam int CNT_W       = 16;

  // idle in every lane
  localparam xgmii_word_t IDLE_WORD  = 64'h0707_0707_0707_0707;
  localparam xgmii_ctrl_t IDLE_CTRL  = 8'hff;
  // local fault ordered set, sequence in lane 0
  localparam xgmii_word_t FAULT_WORD = 64'h0000_0000_0100_009c;
  localparam xgmii_ctrl_t FAULT_CTRL = 8'h01;

  // ========================================
  // register map, byte offsets
  // ========================================

  localparam logic [7:0] REG_CTRL      = 8'h00;
  localparam logic [7:0] REG_STATUS    = 8'h04;
  localparam logic [7:0] REG_TX_LO     = 8'h08;
  localparam logic [7:0] REG_TX_HI     = 8'h0c;
  localparam logic [7:0] REG_RX_LO     = 8'h10;
  localparam logic [7:0] REG_RX_HI     = 8'h14;
  localparam logic [7:0] REG_RX_CTRL   = 8'h18;
  localparam logic [7:0] REG_TX_COUNT  = 8'h1c;
  localparam logic [7:0] REG_RX_COUNT  = 8'h20;
  localparam logic [7:0] REG_OVF_COUNT = 8'h24;

endpackage

`default_nettype wire

// File: xaui_sync_fifo.sv
`default_nettype none

module xaui_sync_fifo #(
  parameter type payload_t = xaui_pkg::xgmii_word_t
) (
  input  wire       mgt_clk,
  input  wire       reset,
  input  wire       flush_i,
  input  wire       push_i,
  input  wire       pop_i,
  input  wire       payload_t data_i,
  output payload_t  data_o,
  output logic      empty_o,
  output logic      full_o
);
  import xaui_pkg::*;

  payload_t              mem [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W:0]   count_q;
  logic                  do_push;
  logic                  do_pop;

  // wrap at the last entry, depth need not be a power of two
  function automatic logic [FIFO_PTR_W-1:0] next_ptr(input logic [FIFO_PTR_W-1:0] ptr);
    if (ptr == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // push on full and pop on empty are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == (FIFO_PTR_W + 1)'(FIFO_DEPTH));

  // first-word fall-through
  assign data_o = mem[rd_ptr_q];

  always_ff @(posedge mgt_clk) begin
    if (do_push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge mgt_clk) begin
    if (reset || flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // occupancy holds when both happen
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: xaui_transfer_engine.sv
`default_nettype none

module xaui_transfer_engine (
  input  wire                        mgt_clk,
  input  wire                        reset,
  input  wire                        flush_i,
  input  wire                        tx_en_i,
  input  wire                        loopback_i,
  input  wire  xaui_pkg::xgmii_word_t tx_head_i,
  input  wire                        tx_empty_i,
  output logic                       tx_pop_o,
  output logic                       rx_push_o,
  output xaui_pkg::rx_entry_t        rx_entry_o,
  input  wire                        rx_full_i,
  input  wire  xaui_pkg::xgmii_word_t xgmii_rxd_i,
  input  wire  xaui_pkg::xgmii_ctrl_t xgmii_rxc_i,
  output xaui_pkg::xgmii_word_t      xgmii_txd_o,
  output xaui_pkg::xgmii_ctrl_t      xgmii_txc_o,
  output logic                       tx_strb_o,
  output logic                       rx_strb_o,
  output logic                       ovf_strb_o,
  output logic                       idle_seen_o,
  output logic                       fault_seen_o
);
  import xaui_pkg::*;

  xgmii_word_t rxd_q;
  xgmii_ctrl_t rxc_q;
  logic        rx_vld_q;
  logic        is_idle;
  logic        is_fault;
  logic        is_store;

  // ========================================
  // transmit
  // ========================================

  assign tx_pop_o = tx_en_i && !tx_empty_i;

  // popped word goes out one cycle later, idle fills the gaps
  always_ff @(posedge mgt_clk) begin
    if (reset || flush_i) begin
      xgmii_txd_o <= IDLE_WORD;
      xgmii_txc_o <= IDLE_CTRL;
      tx_strb_o   <= 1'b0;
    end else if (tx_pop_o) begin
      xgmii_txd_o <= tx_head_i;
      xgmii_txc_o <= '0;
      tx_strb_o   <= 1'b1;
    end else begin
      xgmii_txd_o <= IDLE_WORD;
      xgmii_txc_o <= IDLE_CTRL;
      tx_strb_o   <= 1'b0;
    end
  end

  // ========================================
  // receive
  // ========================================

  // first rx stage, loopback taps the tx register
  always_ff @(posedge mgt_clk) begin
    if (loopback_i) begin
      rxd_q <= xgmii_txd_o;
      rxc_q <= xgmii_txc_o;
    end else begin
      rxd_q <= xgmii_rxd_i;
      rxc_q <= xgmii_rxc_i;
    end
  end

  // stage contents are stale right after reset or flush
  always_ff @(posedge mgt_clk) begin
    if (reset || flush_i) begin
      rx_vld_q <= 1'b0;
    end else begin
      rx_vld_q <= 1'b1;
    end
  end

  // capture decision on the registered word
  assign is_idle  = rx_vld_q && (rxd_q == IDLE_WORD) && (rxc_q == IDLE_CTRL);
  assign is_fault = rx_vld_q && (rxd_q == FAULT_WORD) && (rxc_q == FAULT_CTRL);
  // any other control pattern is kept as well
  assign is_store = rx_vld_q && !is_idle && !is_fault;

  assign rx_entry_o.data = rxd_q;
  assign rx_entry_o.ctrl = rxc_q;
  assign rx_push_o       = is_store && !rx_full_i;

  assign rx_strb_o    = rx_push_o;
  assign ovf_strb_o   = is_store && rx_full_i;
  assign idle_seen_o  = is_idle;
  assign fault_seen_o = is_fault;

endmodule

`default_nettype wire
